// File: copper.f
src/copper_pkg.sv
src/copper_sequencer.sv
src/copper_pos_compare.sv
src/copper_xr_writer.sv
src/copper_top.sv
verification/copper_prog_mem.sv
verification/copper_tb.sv

// File: Makefile
# Verilator build and run for the display coprocessor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= copper_tb
FILELIST  ?= copper.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, grep decides the exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// File: verification/copper_tb.sv
// Directed testbench for the display coprocessor with the raster position driven directly
// Every XR write is acknowledged one cycle after the enable is seen
module copper_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WAIT_LIMIT     = 200;

    logic                     clk;
    logic                     copp_reset;
    logic                     cop_xreg_wr;
    copper_pkg::word_t        cop_xreg_data;
    copper_pkg::raster_pos_t  pos;
    logic                     mem_rd_en;
    copper_pkg::copper_pc_t   mem_rd_addr;
    copper_pkg::copper_insn_t mem_rd_data;
    logic                     xr_wr_en;
    copper_pkg::xr_write_t    xr_wr;
    logic                     xr_ack;
    logic                     ack_next;

    // Logs filled by the monitor
    copper_pkg::xr_write_t    writes[$];
    int                       write_cycles[$];
    copper_pkg::copper_pc_t   reads[$];
    int                       read_cycles[$];
    int                       cycle;
    int                       restart_cycle;
    int                       errors;
    logic [31:0]              rng_state;
    copper_pkg::raster_pos_t  restart_pos;

    copper_top dut0 (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .cop_xreg_wr_i   (cop_xreg_wr),
        .cop_xreg_data_i (cop_xreg_data),
        .pos_i           (pos),
        .mem_rd_en_o     (mem_rd_en),
        .mem_rd_addr_o   (mem_rd_addr),
        .mem_rd_data_i   (mem_rd_data),
        .xr_wr_en_o      (xr_wr_en),
        .xr_wr_o         (xr_wr),
        .xr_ack_i        (xr_ack)
    );

    copper_prog_mem mem0 (
        .clk       (clk),
        .rd_en_i   (mem_rd_en),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Samples at the edge and drives the acknowledge 2 ns later
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (pos == restart_pos) begin
            restart_cycle = cycle;
        end
        if (mem_rd_en) begin
            reads.push_back(mem_rd_addr);
            read_cycles.push_back(cycle);
        end
        ack_next = 1'b0;
        if (xr_wr_en && !xr_ack) begin
            writes.push_back(xr_wr);
            write_cycles.push_back(cycle);
            ack_next = 1'b1;
        end
        #2;
        xr_ack = ack_next;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic copper_pkg::raster_pos_t make_pos(input int v, input int h);
        copper_pkg::raster_pos_t p;
        p.h = copper_pkg::hpos_t'(h);
        p.v = copper_pkg::vpos_t'(v);
        return p;
    endfunction

    // Opcode 3'b000 is WAIT and 3'b001 is SKIP
    function automatic copper_pkg::copper_insn_t cond_insn(input logic [2:0] opc, input int v,
                                                           input int h, input logic ign_v,
                                                           input logic ign_h);
        return {opc, 2'b00, 11'(v), 1'b0, 11'(h), 2'b00, ign_h, ign_v};
    endfunction

    function automatic copper_pkg::copper_insn_t jump_insn(input int target);
        return {3'b010, 1'b0, 11'(target), 17'd0};
    endfunction

    // Expected XR write with the region on top and the field cut to the variant width
    function automatic copper_pkg::xr_write_t expected_write(input copper_pkg::copper_op_t op,
                                                             input logic [12:0] field,
                                                             input copper_pkg::word_t data);
        copper_pkg::xr_write_t w;
        logic [2:0]            region;
        int                    width;
        case (op)
            copper_pkg::MOVER: begin
                region = copper_pkg::XR_REGION_REGS;
                width  = copper_pkg::MOVER_ADDR_W;
            end
            copper_pkg::MOVEF: begin
                region = copper_pkg::XR_REGION_TILE;
                width  = copper_pkg::MOVEF_ADDR_W;
            end
            copper_pkg::MOVEP: begin
                region = copper_pkg::XR_REGION_COLOR;
                width  = copper_pkg::MOVEP_ADDR_W;
            end
            default: begin
                region = copper_pkg::XR_REGION_COPPER;
                width  = copper_pkg::COPP_W;
            end
        endcase
        w.addr = {region, field & 13'((1 << width) - 1)};
        w.data = data;
        return w;
    endfunction

    task automatic compare_write(input string name, input copper_pkg::xr_write_t got,
                                 input copper_pkg::xr_write_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got addr %h data %h, expected addr %h data %h",
                     name, got.addr, got.data, exp.addr, exp.data);
            errors++;
        end
    endtask

    task automatic compare_pc(input string name, input copper_pkg::copper_pc_t got,
                              input copper_pkg::copper_pc_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: %s is %0d where %0d was expected", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_for_writes(input int n);
        int waited;
        waited = 0;
        while (writes.size() < n && waited < WAIT_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (writes.size() < n) begin
            $display("error: only %0d of %0d XR writes arrived in %0d cycles",
                     writes.size(), n, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_for_reads(input int n);
        int waited;
        waited = 0;
        while (reads.size() < n && waited < WAIT_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (reads.size() < n) begin
            $display("error: only %0d of %0d program reads seen in %0d cycles",
                     reads.size(), n, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic clear_logs();
        writes.delete();
        write_cycles.delete();
        reads.delete();
        read_cycles.delete();
    endtask

    task automatic write_ctrl(input logic en, input int init_pc);
        cop_xreg_data = {en, 4'b0000, 11'(init_pc)};
        cop_xreg_wr   = 1'b1;
        wait_cycles(1);
        cop_xreg_wr   = 1'b0;
    endtask

    // Restart is held two cycles so the new initial PC is the one loaded
    task automatic start_program(input int init_pc, input copper_pkg::raster_pos_t p);
        wait_cycles(4);
        clear_logs();
        pos = restart_pos;
        write_ctrl(1'b1, init_pc);
        wait_cycles(1);
        pos = p;
    endtask

    task automatic test_reset_disable();
        repeat (4) begin
            compare_bit("xr_wr_en after reset", xr_wr_en, 1'b0);
            compare_bit("mem_rd_en after reset", mem_rd_en, 1'b0);
            wait_cycles(1);
        end
        clear_logs();
        pos = restart_pos;
        wait_cycles(1);
        pos = make_pos(0, 0);
        wait_cycles(20);
        check_count("reads while disabled", reads.size(), 0);
    endtask

    task automatic test_moves();
        copper_pkg::copper_op_t ops[6];
        copper_pkg::xr_write_t  exp[$];
        logic [12:0]            field;
        copper_pkg::word_t      data;
        ops = '{copper_pkg::MOVER, copper_pkg::MOVEF, copper_pkg::MOVEP,
                copper_pkg::MOVEC, copper_pkg::RSVD, copper_pkg::MOVER};
        for (int i = 0; i < 6; i++) begin
            field = 13'(xorshift32());
            data  = 16'(xorshift32());
            mem0.load_word(copper_pkg::copper_pc_t'(16 + i), {ops[i], field, data});
            if (ops[i] != copper_pkg::RSVD) begin
                exp.push_back(expected_write(ops[i], field, data));
            end
        end
        mem0.load_word(11'd22, cond_insn(3'b000, 0, 0, 1'b1, 1'b1));
        start_program(16, make_pos(10, 10));
        wait_for_writes(5);
        wait_cycles(20);
        check_count("move write count", writes.size(), 5);
        for (int i = 0; i < writes.size() && i < 5; i++) begin
            compare_write($sformatf("move write %0d", i), writes[i], exp[i]);
        end
    endtask

    // Uses the logs of the move run
    task automatic test_pacing();
        int gaps[4];
        gaps = '{4, 4, 4, 8};
        if (write_cycles.size() >= 5) begin
            for (int i = 0; i < 4; i++) begin
                check_count($sformatf("write gap %0d", i),
                            write_cycles[i + 1] - write_cycles[i], gaps[i]);
            end
        end
        // One cycle to take the restart and one INIT cycle
        if (reads.size() > 0) begin
            check_count("restart to first fetch", read_cycles[0] - restart_cycle, 2);
            compare_pc("first fetch address", reads[0], 11'd16);
        end
    endtask

    task automatic wait_case(input logic ign_v, input logic ign_h,
                             input copper_pkg::raster_pos_t hold,
                             input copper_pkg::raster_pos_t go);
        copper_pkg::word_t data;
        data = 16'(xorshift32());
        mem0.load_word(11'd64, cond_insn(3'b000, 100, 200, ign_v, ign_h));
        mem0.load_word(11'd65, {copper_pkg::MOVER, 13'h0042, data});
        start_program(64, hold);
        wait_cycles(40);
        check_count("writes before WAIT target", writes.size(), 0);
        pos = go;
        wait_for_writes(1);
        if (writes.size() > 0) begin
            compare_write("write after WAIT", writes[0],
                          expected_write(copper_pkg::MOVER, 13'h0042, data));
        end
    endtask

    task automatic test_wait();
        wait_case(1'b0, 1'b0, make_pos(99, 300), make_pos(100, 250));
        wait_case(1'b1, 1'b0, make_pos(300, 150), make_pos(10, 250));
        wait_case(1'b0, 1'b1, make_pos(99, 700), make_pos(100, 0));
    endtask

    task automatic test_skip_jump();
        copper_pkg::xr_write_t w_a;
        copper_pkg::xr_write_t w_b;
        w_a = expected_write(copper_pkg::MOVER, 13'h0011, 16'h1111);
        w_b = expected_write(copper_pkg::MOVER, 13'h0022, 16'h2222);
        mem0.load_word(11'd129, {copper_pkg::MOVER, 13'h0011, 16'h1111});
        mem0.load_word(11'd130, {copper_pkg::MOVER, 13'h0022, 16'h2222});
        // Condition holds so the first MOVER is skipped
        mem0.load_word(11'd128, cond_insn(3'b001, 0, 0, 1'b0, 1'b0));
        start_program(128, make_pos(10, 10));
        wait_for_writes(1);
        wait_cycles(20);
        check_count("writes after taken SKIP", writes.size(), 1);
        if (writes.size() > 0) begin
            compare_write("write after taken SKIP", writes[0], w_b);
        end
        // Condition fails so both MOVERs run
        mem0.load_word(11'd128, cond_insn(3'b001, 500, 0, 1'b0, 1'b0));
        start_program(128, make_pos(10, 10));
        wait_for_writes(2);
        wait_cycles(20);
        check_count("writes after failed SKIP", writes.size(), 2);
        if (writes.size() > 1) begin
            compare_write("first write after failed SKIP", writes[0], w_a);
            compare_write("second write after failed SKIP", writes[1], w_b);
        end
        mem0.load_word(11'd160, jump_insn(170));
        mem0.load_word(11'd161, {copper_pkg::MOVER, 13'h0011, 16'h1111});
        mem0.load_word(11'd170, {copper_pkg::MOVER, 13'h0033, 16'h3333});
        start_program(160, make_pos(10, 10));
        wait_for_writes(1);
        wait_cycles(20);
        check_count("writes after JMP", writes.size(), 1);
        if (reads.size() > 1) begin
            compare_pc("read after JMP", reads[1], 11'd170);
        end
        if (writes.size() > 0) begin
            compare_write("write after JMP", writes[0],
                          expected_write(copper_pkg::MOVER, 13'h0033, 16'h3333));
        end
    endtask

    task automatic test_restart_ctrl();
        int n;
        mem0.load_word(11'd200, cond_insn(3'b000, 100, 0, 1'b0, 1'b0));
        start_program(200, make_pos(10, 10));
        wait_cycles(10);
        clear_logs();
        // New initial PC while the WAIT is still polling
        write_ctrl(1'b1, 128);
        wait_cycles(20);
        check_count("reads after mid-frame control write", reads.size(), 0);
        pos = restart_pos;
        wait_cycles(1);
        pos = make_pos(10, 10);
        wait_for_reads(1);
        if (reads.size() > 0) begin
            compare_pc("first read after restart", reads[0], 11'd128);
        end
        for (int i = 224; i < 240; i++) begin
            mem0.load_word(copper_pkg::copper_pc_t'(i), {copper_pkg::RSVD, 29'd0});
        end
        start_program(224, make_pos(10, 10));
        wait_for_reads(3);
        write_ctrl(1'b0, 224);
        n = reads.size();
        wait_cycles(30);
        // At most the fetch already under way may follow the disable
        if (reads.size() - n > 1) begin
            $display("error: %0d program reads followed the disable",
                     reads.size() - n);
            errors++;
        end
    endtask

    initial begin
        restart_pos   = make_pos(copper_pkg::TOTAL_HEIGHT - 1, copper_pkg::TOTAL_WIDTH - 4);
        rng_state     = 32'hee07;
        cycle         = 0;
        restart_cycle = 0;
        errors        = 0;
        copp_reset    = 1'b1;
        cop_xreg_wr   = 1'b0;
        cop_xreg_data = '0;
        pos           = make_pos(0, 0);
        xr_ack        = 1'b0;
        ack_next      = 1'b0;
        wait_cycles(8);
        copp_reset = 1'b0;

        test_reset_disable();
        test_moves();
        test_pacing();
        test_wait();
        test_skip_jump();
        test_restart_ctrl();

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/copper_prog_mem.sv
// Behavioral program memory, one cycle read latency, data held until next strobe
// Unloaded words hold a WAIT with both ignore flags set, so a stray fetch halts
module copper_prog_mem (
    input  logic                     clk,
    input  logic                     rd_en_i,
    input  copper_pkg::copper_pc_t   rd_addr_i,
    output copper_pkg::copper_insn_t rd_data_o
);

    timeunit 1ns;
    timeprecision 1ps;

    copper_pkg::copper_insn_t mem [2**copper_pkg::COPP_W];

    // Fill carries the word index in the V field
    initial begin
        for (int i = 0; i < 2**copper_pkg::COPP_W; i++) begin
            mem[i] = {3'b000, 2'b00, 11'(i), 14'd0, 2'b11};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // Called by the testbench to place instructions
    task automatic load_word(input copper_pkg::copper_pc_t addr,
                             input copper_pkg::copper_insn_t data);
        mem[addr] = data;
    endtask

endmodule

// File: src/copper_top.sv
// Display coprocessor top, 640x480 raster only
// Program memory read latency must be exactly one cycle
module copper_top (
    input  logic                     clk,
    input  logic                     copp_reset,

    // Control register write
    input  logic                     cop_xreg_wr_i,
    input  copper_pkg::word_t        cop_xreg_data_i,

    // Current raster position
    input  copper_pkg::raster_pos_t  pos_i,

    // Program memory read port
    output logic                     mem_rd_en_o,
    output copper_pkg::copper_pc_t   mem_rd_addr_o,
    input  copper_pkg::copper_insn_t mem_rd_data_i,

    // XR register write port
    output logic                     xr_wr_en_o,
    output copper_pkg::xr_write_t    xr_wr_o,
    input  logic                     xr_ack_i
);

    copper_pkg::copper_ctrl_t ctrl_word;
    copper_pkg::copper_insn_t insn;
    logic                     precomp;
    logic                     exec;
    logic                     cond_met;

    assign ctrl_word = copper_pkg::copper_ctrl_t'(cop_xreg_data_i);

    copper_sequencer u_sequencer (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .ctrl_wr_i     (cop_xreg_wr_i),
        .ctrl_data_i   (ctrl_word),
        .pos_i         (pos_i),
        .cond_met_i    (cond_met),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_rd_data_i (mem_rd_data_i),
        .insn_o        (insn),
        .precomp_o     (precomp),
        .exec_o        (exec)
    );

    copper_pos_compare u_pos_compare (
        .clk        (clk),
        .copp_reset (copp_reset),
        .precomp_i  (precomp),
        .insn_i     (insn),
        .pos_i      (pos_i),
        .cond_met_o (cond_met)
    );

    copper_xr_writer u_xr_writer (
        .clk        (clk),
        .copp_reset (copp_reset),
        .exec_i     (exec),
        .insn_i     (insn),
        .xr_ack_i   (xr_ack_i),
        .xr_wr_en_o (xr_wr_en_o),
        .xr_wr_o    (xr_wr_o)
    );

endmodule

// File: src/copper_xr_writer.sv
// XR write port for the MOVE opcodes, enable held until acknowledged
// A newer MOVE overwrites a pending write, there is no back-pressure
module copper_xr_writer (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     exec_i,
    input  copper_pkg::copper_insn_t insn_i,
    input  logic                     xr_ack_i,
    output logic                     xr_wr_en_o,
    output copper_pkg::xr_write_t    xr_wr_o
);

    copper_pkg::copper_op_t op;
    copper_pkg::xr_addr_t   move_addr;
    logic                   is_move;

    assign op = copper_pkg::copper_op_t'(insn_i[31:29]);

    // Address field starts at bit 16, width set by the variant
    always_comb begin
        move_addr = '0;
        is_move   = 1'b1;
        case (op)
            copper_pkg::MOVER: begin
                move_addr        = copper_pkg::xr_addr_t'(insn_i[16 +: copper_pkg::MOVER_ADDR_W]);
                move_addr[15:13] = copper_pkg::XR_REGION_REGS;
            end
            copper_pkg::MOVEF: begin
                move_addr        = copper_pkg::xr_addr_t'(insn_i[16 +: copper_pkg::MOVEF_ADDR_W]);
                move_addr[15:13] = copper_pkg::XR_REGION_TILE;
            end
            copper_pkg::MOVEP: begin
                move_addr        = copper_pkg::xr_addr_t'(insn_i[16 +: copper_pkg::MOVEP_ADDR_W]);
                move_addr[15:13] = copper_pkg::XR_REGION_COLOR;
            end
            copper_pkg::MOVEC: begin
                move_addr        = copper_pkg::xr_addr_t'(insn_i[16 +: copper_pkg::COPP_W]);
                move_addr[15:13] = copper_pkg::XR_REGION_COPPER;
            end
            default: begin
                // Flow control and reserved opcodes write nothing
                is_move = 1'b0;
            end
        endcase
    end

    // Enable, a new MOVE takes priority over the acknowledge
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else if (exec_i && is_move) begin
            xr_wr_en_o <= 1'b1;
        end else if (xr_ack_i) begin
            xr_wr_en_o <= 1'b0;
        end
    end

    // Payload, data word is the low half of the instruction
    always_ff @(posedge clk) begin
        if (exec_i && is_move) begin
            xr_wr_o.addr <= move_addr;
            xr_wr_o.data <= insn_i[15:0];
        end
    end

endmodule

// File: src/copper_pos_compare.sv
// Raster compare for WAIT and SKIP, sampled on the precomp strobe
// Result is valid from the cycle after precomp until the next one
module copper_pos_compare (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     precomp_i,
    input  copper_pkg::copper_insn_t insn_i,
    input  copper_pkg::raster_pos_t  pos_i,
    output logic                     cond_met_o
);

    // Target position and flags from the instruction
    copper_pkg::vpos_t target_v;
    copper_pkg::hpos_t target_h;
    logic              ignore_v;
    logic              ignore_h;
    logic              is_skip;

    logic              v_reached;
    logic              h_reached;

    assign target_v = insn_i[16 +: 11];
    assign target_h = insn_i[4 +: 11];
    assign ignore_v = insn_i[0];
    assign ignore_h = insn_i[1];
    // Low opcode bit separates SKIP from WAIT
    assign is_skip  = insn_i[29];

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            v_reached <= 1'b0;
            h_reached <= 1'b0;
        end else if (precomp_i) begin
            v_reached <= (pos_i.v >= target_v);
            h_reached <= (pos_i.h >= target_h);
        end
    end

    // Both ignored means WAIT never ends and SKIP always skips
    always_comb begin
        if (ignore_v && ignore_h) begin
            cond_met_o = is_skip;
        end else begin
            cond_met_o = (ignore_v || v_reached) && (ignore_h || h_reached);
        end
    end

endmodule

// File: src/copper_sequencer.sv
// Fetch/execute sequencer, never stalls, restarts every frame from the initial PC
// Program memory must return data one cycle after the read strobe
module copper_sequencer (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     ctrl_wr_i,
    input  copper_pkg::copper_ctrl_t ctrl_data_i,
    input  copper_pkg::raster_pos_t  pos_i,
    input  logic                     cond_met_i,
    output logic                     mem_rd_en_o,
    output copper_pkg::copper_pc_t   mem_rd_addr_o,
    input  copper_pkg::copper_insn_t mem_rd_data_i,
    output copper_pkg::copper_insn_t insn_o,
    output logic                     precomp_o,
    output logic                     exec_o
);

    // Control register contents
    logic                      enable;
    copper_pkg::copper_pc_t    init_pc;

    // Execution state
    copper_pkg::copper_state_t state;
    copper_pkg::copper_pc_t    pc;
    copper_pkg::copper_pc_t    pc_skip;
    copper_pkg::copper_insn_t  insn;
    logic                      rd_strobe;

    // Decoded fields of the latched instruction
    copper_pkg::copper_op_t    op;
    copper_pkg::copper_pc_t    jump_target;

    // End of frame marker, last line just before its end
    logic                      frame_restart;

    assign frame_restart =
        (pos_i.h == copper_pkg::hpos_t'(copper_pkg::TOTAL_WIDTH - 4)) &&
        (pos_i.v == copper_pkg::vpos_t'(copper_pkg::TOTAL_HEIGHT - 1));

    assign op          = copper_pkg::copper_op_t'(insn[31:29]);
    assign jump_target = insn[17 +: copper_pkg::COPP_W];

    assign mem_rd_en_o   = rd_strobe;
    assign mem_rd_addr_o = pc;
    assign insn_o        = insn;

    // Strobes for the comparator and the writer
    assign precomp_o = (state == copper_pkg::PRECOMP);
    assign exec_o    = (state == copper_pkg::EXEC);

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            enable    <= 1'b0;
            init_pc   <= '0;
            pc        <= '0;
            state     <= copper_pkg::INIT;
            rd_strobe <= 1'b0;
        end else begin
            // Read strobe is a one cycle pulse
            rd_strobe <= 1'b0;

            // Reserved bits of the control word are not kept
            if (ctrl_wr_i) begin
                enable  <= ctrl_data_i.enable;
                init_pc <= ctrl_data_i.init_pc;
            end

            if (frame_restart) begin
                // New frame, start over from the initial PC
                state <= copper_pkg::INIT;
                pc    <= init_pc;
            end else begin
                case (state)
                    copper_pkg::INIT: begin
                        // First fetch of a frame or after enabling
                        if (enable) begin
                            state     <= copper_pkg::FETCH_WAIT;
                            rd_strobe <= 1'b1;
                        end
                    end
                    copper_pkg::FETCH_WAIT: begin
                        // Memory still sees the old PC this cycle
                        if (enable) begin
                            state <= copper_pkg::LATCH;
                            pc    <= pc + 1'b1;
                        end else begin
                            state <= copper_pkg::INIT;
                        end
                    end
                    copper_pkg::LATCH: begin
                        state <= copper_pkg::PRECOMP;
                    end
                    copper_pkg::PRECOMP: begin
                        state <= copper_pkg::EXEC;
                    end
                    copper_pkg::EXEC: begin
                        case (op)
                            copper_pkg::WAIT: begin
                                // Keep polling the raster until reached
                                if (cond_met_i) begin
                                    state     <= copper_pkg::FETCH_WAIT;
                                    rd_strobe <= 1'b1;
                                end else begin
                                    state <= copper_pkg::PRECOMP;
                                end
                            end
                            copper_pkg::SKIP: begin
                                if (cond_met_i) begin
                                    pc <= pc_skip;
                                end
                                state     <= copper_pkg::FETCH_WAIT;
                                rd_strobe <= 1'b1;
                            end
                            copper_pkg::JUMP: begin
                                pc        <= jump_target;
                                state     <= copper_pkg::FETCH_WAIT;
                                rd_strobe <= 1'b1;
                            end
                            default: begin
                                // MOVEs and the reserved opcode just fetch on
                                state     <= copper_pkg::FETCH_WAIT;
                                rd_strobe <= 1'b1;
                            end
                        endcase
                    end
                    default: begin
                        state <= copper_pkg::INIT;
                    end
                endcase
            end
        end
    end

    // Instruction register and skip target
    always_ff @(posedge clk) begin
        if (state == copper_pkg::LATCH) begin
            insn <= mem_rd_data_i;
        end
        // PC already points past the current instruction here
        if (state == copper_pkg::PRECOMP) begin
            pc_skip <= pc + 1'b1;
        end
    end

endmodule

// File: src/copper_pkg.sv
// Shared types and constants for the display coprocessor
// Only the 640x480 mode is covered (800x525 total raster)
package copper_pkg;

    // Program counter width, 2K instruction words
    localparam int COPP_W = 11;

    // MOVE address field widths per variant
    localparam int MOVER_ADDR_W = 8;
    localparam int MOVEF_ADDR_W = 13;
    localparam int MOVEP_ADDR_W = 9;

    typedef logic [15:0]       word_t;
    typedef logic [15:0]       xr_addr_t;
    typedef logic [COPP_W-1:0] copper_pc_t;
    typedef logic [31:0]       copper_insn_t;
    typedef logic [10:0]       hpos_t;
    typedef logic [10:0]       vpos_t;

    // XR region codes, these land in address bits 15..13
    localparam logic [2:0] XR_REGION_REGS   = 3'd0;
    localparam logic [2:0] XR_REGION_TILE   = 3'd1;
    localparam logic [2:0] XR_REGION_COLOR  = 3'd4;
    localparam logic [2:0] XR_REGION_COPPER = 3'd6;

    // Full raster including blanking
    localparam int TOTAL_WIDTH  = 800;
    localparam int TOTAL_HEIGHT = 525;

    // Opcode in instruction bits 31..29
    typedef enum logic [2:0] {
        WAIT  = 3'd0,
        SKIP  = 3'd1,
        JUMP  = 3'd2,
        MOVER = 3'd3,
        MOVEF = 3'd4,
        MOVEP = 3'd5,
        MOVEC = 3'd6,
        RSVD  = 3'd7
    } copper_op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        INIT       = 3'd0,
        FETCH_WAIT = 3'd1,
        LATCH      = 3'd2,
        PRECOMP    = 3'd3,
        EXEC       = 3'd4
    } copper_state_t;

    typedef struct packed {
        hpos_t h;
        vpos_t v;
    } raster_pos_t;

    typedef struct packed {
        xr_addr_t addr;
        word_t    data;
    } xr_write_t;

    // Control word: enable in bit 15, initial PC in the low bits
    typedef struct packed {
        logic       enable;
        logic [3:0] reserved;
        copper_pc_t init_pc;
    } copper_ctrl_t;

endpackage
